// ==== Bender.yml ====
package:
  name: axi_mem_slave

sources:
  - files:
      - hdl/axi_mem_pkg.sv
      - hdl/mem_write_if.sv
      - hdl/axi_mem_array.sv
      - hdl/axi_write_ctrl.sv
      - hdl/axi_read_ctrl.sv
      - hdl/axi_mem_slave.sv
  - target: test
    files:
      - tests/axi_mem_slave_tb.sv

// ==== hdl/axi_mem_array.sv ====
////////////////////////////////////////////////////////////////////////////
// Word-organized memory for the AXI4 slave
// Byte-strobed write port, registered read port that holds its
// value until the next read enable
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module axi_mem_array #(
   parameter int DATA_BYTES = 4,
   parameter int MEM_BYTES  = 2048
) (
   input  logic                                   conn,
   input  logic                                   arst_n,
   mem_write_if.mem                               wr,
   input  logic                                   rd_en,
   input  logic [$clog2(MEM_BYTES/DATA_BYTES)-1:0] rd_word,
   output logic [DATA_BYTES*8-1:0]                rd_data
);

   localparam int WORDS = MEM_BYTES / DATA_BYTES;

   // Storage, contents undefined until written
   logic [DATA_BYTES*8-1:0] ram [WORDS];

   // Write only the lanes with strobe set
   always_ff @(posedge conn) begin
      if (wr.wr_en) begin
         for (int b = 0; b < DATA_BYTES; b++) begin
            if (wr.wr_strb[b]) begin
               ram[wr.wr_word][b*8 +: 8] <= wr.wr_data[b*8 +: 8];
            end
         end
      end
   end

   // Read register, valid one cycle after rd_en
   always_ff @(posedge conn or negedge arst_n) begin
      if (!arst_n) begin
         rd_data <= '0;
      end else if (rd_en) begin
         rd_data <= ram[rd_word];
      end
   end

endmodule

// ==== hdl/axi_mem_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// AXI4 memory slave shared definitions
// Bus field widths and types, response codes and the controller
// state encodings used by the write and read paths
////////////////////////////////////////////////////////////////////////////

package axi_mem_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Field widths
   ////////////////////////////////////////////////////////////////////////////
   localparam int ADDR_BITS = 32;
   localparam int ID_BITS   = 4;
   localparam int LEN_BITS  = 8;
   localparam int RESP_BITS = 2;

   // Byte address on the bus
   typedef logic [ADDR_BITS-1:0] addr_t;
   // Transaction ID, echoed on B and R
   typedef logic [ID_BITS-1:0]   id_t;
   // Beats in burst minus one
   typedef logic [LEN_BITS-1:0]  len_t;
   typedef logic [RESP_BITS-1:0] resp_t;

   // Response codes
   localparam resp_t RESP_OKAY   = 2'd0;
   // Beat count did not match awlen+1
   localparam resp_t RESP_SLVERR = 2'd2;

   ////////////////////////////////////////////////////////////////////////////
   // Controller states
   ////////////////////////////////////////////////////////////////////////////
   typedef enum logic [1:0] {
      W_IDLE,
      W_DATA,
      W_RESP
   } wr_state_t;

   typedef enum logic [1:0] {
      R_IDLE,
      R_FETCH,
      R_SEND
   } rd_state_t;

endpackage

// ==== hdl/axi_mem_slave.sv ====
////////////////////////////////////////////////////////////////////////////
// AXI4 memory slave top level
// Independent write and read controllers sharing one byte-strobed
// memory, AXI channels as plain ports
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module axi_mem_slave #(
   parameter int DATA_BYTES = 4,
   parameter int MEM_BYTES  = 2048
) (
   input  logic                    conn,
   input  logic                    arst_n,
   // Write address
   input  logic                    awvalid,
   output logic                    awready,
   input  axi_mem_pkg::addr_t      awaddr,
   input  axi_mem_pkg::id_t        awid,
   input  axi_mem_pkg::len_t       awlen,
   // Write data
   input  logic                    wvalid,
   output logic                    wready,
   input  logic [DATA_BYTES*8-1:0] wdata,
   input  logic [DATA_BYTES-1:0]   wstrb,
   input  logic                    wlast,
   // Write response
   output logic                    bvalid,
   input  logic                    bready,
   output axi_mem_pkg::resp_t      bresp,
   output axi_mem_pkg::id_t        bid,
   // Read address
   input  logic                    arvalid,
   output logic                    arready,
   input  axi_mem_pkg::addr_t      araddr,
   input  axi_mem_pkg::id_t        arid,
   input  axi_mem_pkg::len_t       arlen,
   // Read data
   output logic                    rvalid,
   input  logic                    rready,
   output logic [DATA_BYTES*8-1:0] rdata,
   output axi_mem_pkg::resp_t      rresp,
   output axi_mem_pkg::id_t        rid,
   output logic                    rlast
);

   localparam int WORD_BITS = $clog2(MEM_BYTES / DATA_BYTES);

   // Read port between read controller and memory
   logic                    rd_en;
   logic [WORD_BITS-1:0]    rd_word;
   logic [DATA_BYTES*8-1:0] rd_data;

   mem_write_if #(.DATA_BYTES(DATA_BYTES), .MEM_BYTES(MEM_BYTES)) u_mem_wr_if ();

   // Write path
   axi_write_ctrl #(.DATA_BYTES(DATA_BYTES), .MEM_BYTES(MEM_BYTES)) u_axi_write_ctrl (
      .conn    (conn),    .arst_n  (arst_n),
      .awvalid (awvalid), .awready (awready), .awaddr (awaddr),
      .awid    (awid),    .awlen   (awlen),
      .wvalid  (wvalid),  .wready  (wready),  .wdata  (wdata),
      .wstrb   (wstrb),   .wlast   (wlast),
      .bvalid  (bvalid),  .bready  (bready),  .bresp  (bresp),
      .bid     (bid),     .mem     (u_mem_wr_if.ctrl)
   );

   // Read path
   axi_read_ctrl #(.DATA_BYTES(DATA_BYTES), .MEM_BYTES(MEM_BYTES)) u_axi_read_ctrl (
      .conn    (conn),    .arst_n  (arst_n),
      .arvalid (arvalid), .arready (arready), .araddr  (araddr),
      .arid    (arid),    .arlen   (arlen),
      .rvalid  (rvalid),  .rready  (rready),  .rdata   (rdata),
      .rresp   (rresp),   .rid     (rid),     .rlast   (rlast),
      .rd_en   (rd_en),   .rd_word (rd_word), .rd_data (rd_data)
   );

   // Shared storage
   axi_mem_array #(.DATA_BYTES(DATA_BYTES), .MEM_BYTES(MEM_BYTES)) u_axi_mem_array (
      .conn    (conn),
      .arst_n  (arst_n),
      .wr      (u_mem_wr_if.mem),
      .rd_en   (rd_en),
      .rd_word (rd_word),
      .rd_data (rd_data)
   );

endmodule

// ==== hdl/axi_read_ctrl.sv ====
////////////////////////////////////////////////////////////////////////////
// AXI4 read path controller
// Accepts one AR burst and returns arlen+1 R beats from memory,
// one fetch per beat, rlast on the final beat
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module axi_read_ctrl #(
   parameter int DATA_BYTES = 4,
   parameter int MEM_BYTES  = 2048
) (
   input  logic                                   conn,
   input  logic                                   arst_n,
   // Read address
   input  logic                                   arvalid,
   output logic                                   arready,
   input  axi_mem_pkg::addr_t                     araddr,
   input  axi_mem_pkg::id_t                       arid,
   input  axi_mem_pkg::len_t                      arlen,
   // Read data
   output logic                                   rvalid,
   input  logic                                   rready,
   output logic [DATA_BYTES*8-1:0]                rdata,
   output axi_mem_pkg::resp_t                     rresp,
   output axi_mem_pkg::id_t                       rid,
   output logic                                   rlast,
   // Memory read port
   output logic                                   rd_en,
   output logic [$clog2(MEM_BYTES/DATA_BYTES)-1:0] rd_word,
   input  logic [DATA_BYTES*8-1:0]                rd_data
);

   localparam int WORD_BITS = $clog2(MEM_BYTES / DATA_BYTES);
   localparam int OFF_BITS  = $clog2(DATA_BYTES);

   axi_mem_pkg::rd_state_t state;
   // Beats sent so far
   axi_mem_pkg::len_t      beat_cnt;
   logic [WORD_BITS-1:0]   rd_ptr;
   axi_mem_pkg::len_t      burst_len;
   axi_mem_pkg::id_t       burst_id;
   logic                   r_hs;

   assign arready = (state == axi_mem_pkg::R_IDLE);
   assign rd_en   = (state == axi_mem_pkg::R_FETCH);
   assign rd_word = rd_ptr;
   assign rvalid  = (state == axi_mem_pkg::R_SEND);
   // Memory holds the word until the next fetch
   assign rdata   = rd_data;
   assign rresp   = axi_mem_pkg::RESP_OKAY;
   assign rid     = burst_id;
   // Gated so it stays low outside a beat
   assign rlast   = rvalid && (beat_cnt == burst_len);
   assign r_hs    = rvalid && rready;

   ////////////////////////////////////////////////////////////////////////////
   // FSM
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge conn or negedge arst_n) begin
      if (!arst_n) begin
         state    <= axi_mem_pkg::R_IDLE;
         beat_cnt <= '0;
      end else begin
         case (state)
            axi_mem_pkg::R_IDLE: begin
               if (arvalid) begin
                  beat_cnt <= '0;
                  state    <= axi_mem_pkg::R_FETCH;
               end
            end
            // One cycle of rd_en
            axi_mem_pkg::R_FETCH: state <= axi_mem_pkg::R_SEND;
            axi_mem_pkg::R_SEND: begin
               if (r_hs) begin
                  if (rlast) begin
                     state <= axi_mem_pkg::R_IDLE;
                  end else begin
                     beat_cnt <= beat_cnt + 1'b1;
                     state    <= axi_mem_pkg::R_FETCH;
                  end
               end
            end
            default: state <= axi_mem_pkg::R_IDLE;
         endcase
      end
   end

   // Burst payload and word pointer
   always_ff @(posedge conn) begin
      if (arvalid && arready) begin
         rd_ptr    <= araddr[OFF_BITS +: WORD_BITS];
         burst_id  <= arid;
         burst_len <= arlen;
      end else if (r_hs) begin
         // Next word, wraps at end of memory
         rd_ptr <= rd_ptr + 1'b1;
      end
   end

   // R beat held under back-pressure, memory register included
   assert property (@(posedge conn) disable iff (!arst_n)
      rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rlast));

endmodule

// ==== hdl/axi_write_ctrl.sv ====
////////////////////////////////////////////////////////////////////////////
// AXI4 write path controller
// Accepts one AW burst, writes its W beats into memory at
// incrementing word addresses and returns one B response.
// SLVERR when the beat count differs from awlen+1
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module axi_write_ctrl #(
   parameter int DATA_BYTES = 4,
   parameter int MEM_BYTES  = 2048
) (
   input  logic                    conn,
   input  logic                    arst_n,
   // Write address
   input  logic                    awvalid,
   output logic                    awready,
   input  axi_mem_pkg::addr_t      awaddr,
   input  axi_mem_pkg::id_t        awid,
   input  axi_mem_pkg::len_t       awlen,
   // Write data
   input  logic                    wvalid,
   output logic                    wready,
   input  logic [DATA_BYTES*8-1:0] wdata,
   input  logic [DATA_BYTES-1:0]   wstrb,
   input  logic                    wlast,
   // Write response
   output logic                    bvalid,
   input  logic                    bready,
   output axi_mem_pkg::resp_t      bresp,
   output axi_mem_pkg::id_t        bid,
   mem_write_if.ctrl               mem
);

   localparam int WORD_BITS = $clog2(MEM_BYTES / DATA_BYTES);
   localparam int OFF_BITS  = $clog2(DATA_BYTES);

   axi_mem_pkg::wr_state_t state;
   // Beats taken so far in this burst
   axi_mem_pkg::len_t      beat_cnt;
   // Set once a beat past awlen+1 arrived without wlast
   logic                   len_err;
   logic [WORD_BITS-1:0]   wr_ptr;
   axi_mem_pkg::len_t      burst_len;
   axi_mem_pkg::id_t       burst_id;
   logic                   w_hs;

   assign awready = (state == axi_mem_pkg::W_IDLE);
   assign wready  = (state == axi_mem_pkg::W_DATA);
   assign bvalid  = (state == axi_mem_pkg::W_RESP);
   assign bid     = burst_id;
   assign w_hs    = wvalid && wready;

   // Memory write in the same cycle as the W handshake
   assign mem.wr_en   = w_hs;
   assign mem.wr_word = wr_ptr;
   assign mem.wr_data = wdata;
   assign mem.wr_strb = wstrb;

   ////////////////////////////////////////////////////////////////////////////
   // FSM and beat counting
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge conn or negedge arst_n) begin
      if (!arst_n) begin
         state    <= axi_mem_pkg::W_IDLE;
         beat_cnt <= '0;
         len_err  <= 1'b0;
      end else begin
         case (state)
            axi_mem_pkg::W_IDLE: begin
               if (awvalid) begin
                  beat_cnt <= '0;
                  len_err  <= 1'b0;
                  state    <= axi_mem_pkg::W_DATA;
               end
            end
            axi_mem_pkg::W_DATA: begin
               if (w_hs) begin
                  beat_cnt <= beat_cnt + 1'b1;
                  if (wlast) begin
                     state <= axi_mem_pkg::W_RESP;
                  end else if (beat_cnt == burst_len) begin
                     // Burst runs long, still stored
                     len_err <= 1'b1;
                  end
               end
            end
            axi_mem_pkg::W_RESP: begin
               // Hold response until master takes it
               if (bready) begin
                  state <= axi_mem_pkg::W_IDLE;
               end
            end
            default: state <= axi_mem_pkg::W_IDLE;
         endcase
      end
   end

   // Burst payload, address and response
   always_ff @(posedge conn) begin
      if (awvalid && awready) begin
         // Drop byte offset, wrap with memory size
         wr_ptr    <= awaddr[OFF_BITS +: WORD_BITS];
         burst_id  <= awid;
         burst_len <= awlen;
      end else if (w_hs) begin
         wr_ptr <= wr_ptr + 1'b1;
      end
      // Short burst fails the compare, long one sets len_err
      if (w_hs && wlast) begin
         bresp <= (!len_err && beat_cnt == burst_len) ? axi_mem_pkg::RESP_OKAY
                                                      : axi_mem_pkg::RESP_SLVERR;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Checks
   ////////////////////////////////////////////////////////////////////////////
   // B beat held under back-pressure
   assert property (@(posedge conn) disable iff (!arst_n)
      bvalid && !bready |=> bvalid && $stable(bresp) && $stable(bid));

   // No W beat accepted before its AW
   assert property (@(posedge conn) disable iff (!arst_n)
      $rose(wready) |-> $past(awvalid && awready));

endmodule

// ==== hdl/mem_write_if.sv ====
////////////////////////////////////////////////////////////////////////////
// Byte-strobed memory write port
// Carries one word write per cycle from the write controller
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

interface mem_write_if #(
   parameter int DATA_BYTES = 4,
   parameter int MEM_BYTES  = 2048
);

   localparam int WORD_BITS = $clog2(MEM_BYTES / DATA_BYTES);

   // Write this cycle
   logic                    wr_en;
   // Word index, not byte address
   logic [WORD_BITS-1:0]    wr_word;
   logic [DATA_BYTES*8-1:0] wr_data;
   // One bit per byte lane
   logic [DATA_BYTES-1:0]   wr_strb;

   // Write controller side
   modport ctrl (
      output wr_en, wr_word, wr_data, wr_strb
   );

   // Memory side
   modport mem (
      input  wr_en, wr_word, wr_data, wr_strb
   );

endinterface

// ==== sim.f ====
hdl/axi_mem_pkg.sv
hdl/mem_write_if.sv
hdl/axi_mem_array.sv
hdl/axi_write_ctrl.sv
hdl/axi_read_ctrl.sv
hdl/axi_mem_slave.sv
tests/axi_mem_slave_tb.sv

// ==== tests/axi_mem_slave_tb.sv ====
////////////////////////////////////////////////////////////////////////////
// Testbench for the AXI4 memory slave
// Fills the memory, then runs single, random, length-mismatch,
// back-pressure and wrapping bursts against a byte-level model
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module axi_mem_slave_tb;

   localparam int DATA_BYTES = 4;
   localparam int MEM_BYTES  = 2048;
   localparam int DATA_BITS  = DATA_BYTES * 8;
   // Write data sources
   localparam int RAND_STRB  = 0;
   localparam int FULL_STRB  = 1;
   localparam int FILL_DATA  = 2;
   localparam int FILL_BURSTS  = MEM_BYTES / (256 * DATA_BYTES);
   localparam int RAND_BURSTS  = 20;
   localparam int STALL_BURSTS = 16;
   // Writes plus reads over all tests
   localparam int NUM_BURSTS = FILL_BURSTS + 2 + 2 * RAND_BURSTS + 8 + 2 * STALL_BURSTS + 4;
   localparam longint TIMEOUT_NS = longint'(NUM_BURSTS) * 256 * 20 * 10;

   typedef struct packed {
      axi_mem_pkg::id_t   id;
      axi_mem_pkg::resp_t resp;
   } b_beat_t;

   typedef struct packed {
      logic [DATA_BITS-1:0] data;
      axi_mem_pkg::id_t     id;
      logic                 last;
   } r_beat_t;

   logic                    conn;
   logic                    arst_n;
   logic                    awvalid, awready, wvalid, wready, wlast;
   axi_mem_pkg::addr_t      awaddr, araddr;
   axi_mem_pkg::id_t        awid, bid, arid, rid;
   axi_mem_pkg::len_t       awlen, arlen;
   logic [DATA_BITS-1:0]    wdata, rdata;
   logic [DATA_BYTES-1:0]   wstrb;
   logic                    bvalid, bready, arvalid, arready, rvalid, rready, rlast;
   axi_mem_pkg::resp_t      bresp, rresp;

   // Byte-level model of the memory
   logic [7:0]  ref_mem [MEM_BYTES];
   b_beat_t     exp_b [$];
   r_beat_t     exp_r [$];
   logic [31:0] lcg_state = 32'hf2e9_81b9;
   // Back-pressure stretches, active only when stall_en
   logic        stall_en;
   int          b_hold;
   int          r_hold;

   axi_mem_slave #(.DATA_BYTES(DATA_BYTES), .MEM_BYTES(MEM_BYTES)) u_axi_mem_slave (.*);

   initial begin
      conn = 1'b0;
      forever #5 conn = ~conn;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Helpers and reference model
   ////////////////////////////////////////////////////////////////////////////
   function automatic logic [31:0] rand32();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      // Low LCG bits have short periods, swap halves
      return {lcg_state[15:0], lcg_state[31:16]};
   endfunction

   // Fill pattern from the whole byte address
   function automatic logic [DATA_BITS-1:0] fill_word(input int unsigned a);
      return DATA_BITS'({~a[15:0], a[15:0]});
   endfunction

   // Byte address of a beat, word aligned, wrapped to the memory
   function automatic int unsigned beat_addr(input axi_mem_pkg::addr_t start, input int beat);
      return ((start / DATA_BYTES + beat) * DATA_BYTES) % MEM_BYTES;
   endfunction

   function automatic void store_beat(input int unsigned a, input logic [DATA_BITS-1:0] d,
                                      input logic [DATA_BYTES-1:0] s);
      for (int b = 0; b < DATA_BYTES; b++) begin
         if (s[b]) ref_mem[a + b] = d[b*8 +: 8];
      end
   endfunction

   // Expected read word at an aligned byte address
   function automatic logic [DATA_BITS-1:0] ref_word(input int unsigned a);
      logic [DATA_BITS-1:0] w;
      for (int b = 0; b < DATA_BYTES; b++) w[b*8 +: 8] = ref_mem[a + b];
      return w;
   endfunction

   task automatic abort_run();
      $display("Finished with errors");
      $fatal(1, "Simulation stopped on failure");
   endtask

   task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
      if (got !== exp) begin
         $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
         abort_run();
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Bus tasks, entered and left on a falling edge
   ////////////////////////////////////////////////////////////////////////////
   task automatic write_burst(input axi_mem_pkg::addr_t addr, input axi_mem_pkg::id_t id,
                              input axi_mem_pkg::len_t len, input int beats, input int kind);
      logic [DATA_BITS-1:0]  d;
      logic [DATA_BYTES-1:0] s;
      b_beat_t               eb;
      eb.id   = id;
      // OKAY only when the beat count matches awlen+1
      eb.resp = (beats == int'(len) + 1) ? axi_mem_pkg::RESP_OKAY : axi_mem_pkg::RESP_SLVERR;
      exp_b.push_back(eb);
      awvalid = 1'b1;
      awaddr  = addr;
      awid    = id;
      awlen   = len;
      while (!awready) @(negedge conn);
      @(negedge conn);
      awvalid = 1'b0;
      for (int i = 0; i < beats; i++) begin
         // Random gap in W valid
         if (kind != FILL_DATA && rand32() % 4 == 0) begin
            wvalid = 1'b0;
            @(negedge conn);
         end
         d = (kind == FILL_DATA) ? fill_word(beat_addr(addr, i)) : DATA_BITS'(rand32());
         s = (kind == RAND_STRB) ? DATA_BYTES'(rand32()) : '1;
         wvalid = 1'b1;
         wdata  = d;
         wstrb  = s;
         wlast  = (i == beats - 1);
         while (!wready) @(negedge conn);
         // Handshake on the next rising edge
         store_beat(beat_addr(addr, i), d, s);
         @(negedge conn);
      end
      wvalid = 1'b0;
      wlast  = 1'b0;
      while (exp_b.size() != 0) @(negedge conn);
   endtask

   task automatic read_burst(input axi_mem_pkg::addr_t addr, input axi_mem_pkg::id_t id,
                             input axi_mem_pkg::len_t len);
      r_beat_t er;
      for (int i = 0; i <= int'(len); i++) begin
         er.data = ref_word(beat_addr(addr, i));
         er.id   = id;
         er.last = (i == int'(len));
         exp_r.push_back(er);
      end
      arvalid = 1'b1;
      araddr  = addr;
      arid    = id;
      arlen   = len;
      while (!arready) @(negedge conn);
      @(negedge conn);
      arvalid = 1'b0;
      while (exp_r.size() != 0) @(negedge conn);
   endtask

   // Random bready and rready low stretches of 1 to 8 cycles
   always @(negedge conn) begin
      if (stall_en && b_hold == 0 && rand32() % 4 == 0) b_hold = 1 + rand32() % 8;
      else if (b_hold != 0) b_hold = b_hold - 1;
      if (stall_en && r_hold == 0 && rand32() % 4 == 0) r_hold = 1 + rand32() % 8;
      else if (r_hold != 0) r_hold = r_hold - 1;
      bready = (b_hold == 0);
      rready = (r_hold == 0);
   end

   ////////////////////////////////////////////////////////////////////////////
   // Response compare, sampled at the handshake edge
   ////////////////////////////////////////////////////////////////////////////
   always @(posedge conn) begin
      b_beat_t eb;
      r_beat_t er;
      if (arst_n && bvalid && bready) begin
         if (exp_b.size() == 0) begin
            $display("B response arrived with no write burst outstanding");
            abort_run();
         end else begin
            eb = exp_b.pop_front();
            check("bid", bid, eb.id);
            check("bresp", bresp, eb.resp);
         end
      end
      if (arst_n && rvalid && rready) begin
         if (exp_r.size() == 0) begin
            $display("R beat arrived beyond the requested burst length");
            abort_run();
         end else begin
            er = exp_r.pop_front();
            check("rdata", rdata, er.data);
            check("rid", rid, er.id);
            check("rresp", rresp, axi_mem_pkg::RESP_OKAY);
            check("rlast", rlast, er.last);
         end
      end
   end

   initial begin
      #(TIMEOUT_NS);
      $display("Timeout: bursts did not complete within %0d ns", TIMEOUT_NS);
      abort_run();
   end

   ////////////////////////////////////////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////////////////////////////////////////
   initial begin
      axi_mem_pkg::addr_t a;
      axi_mem_pkg::len_t  l;
      arst_n   = 1'b0;
      awvalid  = 1'b0;
      awaddr   = '0;
      awid     = '0;
      awlen    = '0;
      wvalid   = 1'b0;
      wdata    = '0;
      wstrb    = '0;
      wlast    = 1'b0;
      bready   = 1'b1;
      arvalid  = 1'b0;
      araddr   = '0;
      arid     = '0;
      arlen    = '0;
      rready   = 1'b1;
      stall_en = 1'b0;
      b_hold   = 0;
      r_hold   = 0;
      repeat (3) @(negedge conn);
      arst_n = 1'b1;
      // Idle outputs after reset
      check("bvalid", bvalid, 0);
      check("rvalid", rvalid, 0);
      check("wready", wready, 0);
      check("rlast", rlast, 0);
      check("awready", awready, 1);
      check("arready", arready, 1);
      for (int f = 0; f < FILL_BURSTS; f++) begin
         write_burst(f * 256 * DATA_BYTES, 4'h0, 8'd255, 256, FILL_DATA);
      end
      // Single beat, full strobe
      write_burst(32'h40, 4'h5, 8'd0, 1, FULL_STRB);
      read_burst(32'h40, 4'ha, 8'd0);
      for (int n = 0; n < RAND_BURSTS; n++) begin
         a = rand32() & ~(DATA_BYTES - 1);
         l = rand32() % 16;
         write_burst(a, axi_mem_pkg::id_t'(rand32()), l, int'(l) + 1, RAND_STRB);
         read_burst(a, axi_mem_pkg::id_t'(rand32()), l);
      end
      // wlast early, then late, every beat still stored
      write_burst(32'h100, 4'h1, 8'd5, 3, RAND_STRB);
      read_burst(32'h100, 4'h1, 8'd2);
      write_burst(32'h200, 4'h2, 8'd2, 5, RAND_STRB);
      read_burst(32'h200, 4'h2, 8'd4);
      write_burst(32'h300, 4'h3, 8'd0, 2, FULL_STRB);
      read_burst(32'h300, 4'h3, 8'd1);
      write_burst(32'h400, 4'h4, 8'd7, 1, FULL_STRB);
      read_burst(32'h400, 4'h4, 8'd0);
      stall_en = 1'b1;
      for (int n = 0; n < STALL_BURSTS; n++) begin
         a = rand32() & ~(DATA_BYTES - 1);
         l = rand32() % 16;
         write_burst(a, axi_mem_pkg::id_t'(rand32()), l, int'(l) + 1, RAND_STRB);
         read_burst(a, axi_mem_pkg::id_t'(rand32()), l);
      end
      stall_en = 1'b0;
      // Across the top of memory, high address bits ignored
      write_burst(MEM_BYTES - 3 * DATA_BYTES, 4'h6, 8'd7, 8, RAND_STRB);
      read_burst(MEM_BYTES - 3 * DATA_BYTES, 4'h7, 8'd7);
      write_burst(32'h8000_0000 | (MEM_BYTES - DATA_BYTES), 4'h8, 8'd3, 4, FULL_STRB);
      read_burst(MEM_BYTES - DATA_BYTES, 4'h9, 8'd3);
      repeat (4) @(negedge conn);
      if (exp_b.size() != 0 || exp_r.size() != 0) begin
         $display("Responses still outstanding at the end of the test");
         abort_run();
      end else begin
         $display("Finished with no errors");
         $finish;
      end
   end

endmodule
